// File: Makefile
SRCS := $(wildcard rtl/*.sv) $(wildcard tb/*.sv)

.PHONY: all run clean

all: obj_dir/Vsoc_top_tb

obj_dir/Vsoc_top_tb: build.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module soc_top_tb -f build.f

run: obj_dir/Vsoc_top_tb
	./obj_dir/Vsoc_top_tb

clean:
	rm -rf obj_dir

// File: build.f
rtl/bus_pkg.sv
rtl/soc_map_pkg.sv
rtl/mem_if.sv
rtl/bus_ctrl.sv
rtl/l2_mem.sv
rtl/uart_apb_bridge.sv
rtl/ctrl_regs.sv
rtl/soc_top.sv
tb/tb_clk_gen.sv
tb/soc_top_asserts.sv
tb/soc_top_tb.sv

// File: rtl/bus_ctrl.sv
////////////////////////////////////////////////////////////
// Single-outstanding request router
// gnt_o is high when idle and in the response cycle
// Targets see the address as an offset from their base
// Unmapped requests answer with err_o and zero data
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module bus_ctrl (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               req_i,
  input  logic               we_i,
  input  bus_pkg::bus_addr_t addr_i,
  input  bus_pkg::bus_word_t wdata_i,
  input  bus_pkg::bus_strb_t be_i,
  output logic               gnt_o,
  output logic               rvalid_o,
  output logic               err_o,
  output bus_pkg::bus_word_t rdata_o,
  input  logic               uart_err_i,
  mem_if.initiator           l2_bus,
  mem_if.initiator           uart_bus,
  mem_if.initiator           ctrl_bus
);

  logic                     accept;
  logic                     busy_q;
  logic                     pulse_q;
  logic                     none_rvalid_q;
  soc_map_pkg::soc_region_e region_d;
  soc_map_pkg::soc_region_e region_q;
  bus_pkg::bus_addr_t       offset_d;
  bus_pkg::bus_addr_t       addr_q;
  logic                     we_q;
  bus_pkg::bus_word_t       wdata_q;
  bus_pkg::bus_strb_t       be_q;

  assign gnt_o  = !busy_q || rvalid_o;
  assign accept = req_i && gnt_o;

  // Address decode, wrap-around subtraction covers both bounds
  always_comb begin
    region_d = soc_map_pkg::RegionNone;
    offset_d = addr_i;
    if ((addr_i - soc_map_pkg::DramBase) < soc_map_pkg::DramLength) begin
      region_d = soc_map_pkg::RegionDram;
      offset_d = addr_i - soc_map_pkg::DramBase;
    end else if ((addr_i - soc_map_pkg::UartBase) < soc_map_pkg::UartLength) begin
      region_d = soc_map_pkg::RegionUart;
      offset_d = addr_i - soc_map_pkg::UartBase;
    end else if ((addr_i - soc_map_pkg::CtrlBase) < soc_map_pkg::CtrlLength) begin
      region_d = soc_map_pkg::RegionCtrl;
      offset_d = addr_i - soc_map_pkg::CtrlBase;
    end
  end

  ////////////////////////////////////////////////////////////
  // Idle/busy machine
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q        <= 1'b0;
      pulse_q       <= 1'b0;
      none_rvalid_q <= 1'b0;
      region_q      <= soc_map_pkg::RegionNone;
    end else begin
      pulse_q       <= accept;
      // Unmapped answer mirrors the one-cycle target latency
      none_rvalid_q <= pulse_q && (region_q == soc_map_pkg::RegionNone);
      if (accept) begin
        busy_q   <= 1'b1;
        region_q <= region_d;
      end else if (rvalid_o) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q  <= offset_d;
      we_q    <= we_i;
      wdata_q <= wdata_i;
      be_q    <= be_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Request fan-out
  ////////////////////////////////////////////////////////////

  assign l2_bus.req   = pulse_q && (region_q == soc_map_pkg::RegionDram);
  assign l2_bus.we    = we_q;
  assign l2_bus.addr  = addr_q;
  assign l2_bus.wdata = wdata_q;
  assign l2_bus.be    = be_q;

  assign uart_bus.req   = pulse_q && (region_q == soc_map_pkg::RegionUart);
  assign uart_bus.we    = we_q;
  assign uart_bus.addr  = addr_q;
  assign uart_bus.wdata = wdata_q;
  assign uart_bus.be    = be_q;

  assign ctrl_bus.req   = pulse_q && (region_q == soc_map_pkg::RegionCtrl);
  assign ctrl_bus.we    = we_q;
  assign ctrl_bus.addr  = addr_q;
  assign ctrl_bus.wdata = wdata_q;
  assign ctrl_bus.be    = be_q;

  // Response from the routed target only
  always_comb begin
    case (region_q)
      soc_map_pkg::RegionDram: begin
        rvalid_o = l2_bus.rvalid;
        rdata_o  = l2_bus.rdata;
        err_o    = 1'b0;
      end
      soc_map_pkg::RegionUart: begin
        rvalid_o = uart_bus.rvalid;
        rdata_o  = uart_bus.rdata;
        err_o    = uart_err_i;
      end
      soc_map_pkg::RegionCtrl: begin
        rvalid_o = ctrl_bus.rvalid;
        rdata_o  = ctrl_bus.rdata;
        err_o    = 1'b0;
      end
      default: begin
        rvalid_o = none_rvalid_q;
        rdata_o  = '0;
        err_o    = none_rvalid_q;
      end
    endcase
  end

endmodule

// File: rtl/bus_pkg.sv
////////////////////////////////////////////////////////////
// Bus word, address and strobe types of the fabric
// One strobe bit per byte of the 64-bit word
// Lane 0 of the APB view is the low half (address bit 2 clear)
////////////////////////////////////////////////////////////

package bus_pkg;

  localparam int unsigned AddrWidth    = 32;
  localparam int unsigned DataWidth    = 64;
  localparam int unsigned StrbWidth    = DataWidth / 8;
  localparam int unsigned ApbDataWidth = 32;
  localparam int unsigned OffsetWidth  = $clog2(StrbWidth);

  typedef logic [AddrWidth-1:0]    bus_addr_t;
  typedef logic [DataWidth-1:0]    bus_word_t;
  typedef logic [StrbWidth-1:0]    bus_strb_t;
  typedef logic [ApbDataWidth-1:0] apb_word_t;

  // Same 64 bits, seen whole or as two APB lanes
  typedef union packed {
    bus_word_t                                 word;
    apb_word_t [DataWidth/ApbDataWidth-1:0]    lane;
  } bus_word_u;

  // Byte-enabled update of a stored word
  function automatic bus_word_t merge_be(bus_word_t old_w, bus_word_t new_w, bus_strb_t be);
    bus_word_t res;
    res = old_w;
    for (int i = 0; i < StrbWidth; i++) begin
      if (be[i]) res[8*i +: 8] = new_w[8*i +: 8];
    end
    return res;
  endfunction

endpackage

// File: rtl/ctrl_regs.sv
////////////////////////////////////////////////////////////
// Exit and counter-enable registers
// Any other offset reads zero, writes to it are dropped
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module ctrl_regs (
  input  logic               clk_i,
  input  logic               rst_n_i,
  mem_if.target              bus,
  output bus_pkg::bus_word_t exit_o,
  output bus_pkg::bus_word_t hw_cnt_en_o
);

  logic               sel_exit;
  logic               sel_cnt;
  logic               rvalid_q;
  bus_pkg::bus_word_t exit_q;
  bus_pkg::bus_word_t hw_cnt_en_q;
  bus_pkg::bus_word_t rdata_q;

  assign sel_exit = (bus.addr == soc_map_pkg::ExitOffset);
  assign sel_cnt  = (bus.addr == soc_map_pkg::HwCntEnOffset);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      exit_q      <= '0;
      hw_cnt_en_q <= '0;
      rvalid_q    <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
      if (bus.req && bus.we) begin
        if (sel_exit) begin
          exit_q <= bus_pkg::merge_be(exit_q, bus.wdata, bus.be);
        end
        if (sel_cnt) begin
          hw_cnt_en_q <= bus_pkg::merge_be(hw_cnt_en_q, bus.wdata, bus.be);
        end
      end
    end
  end

  // Readback
  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      if (sel_exit) begin
        rdata_q <= exit_q;
      end else if (sel_cnt) begin
        rdata_q <= hw_cnt_en_q;
      end else begin
        rdata_q <= '0;
      end
    end
  end

  assign bus.rdata   = rdata_q;
  assign bus.rvalid  = rvalid_q;
  assign exit_o      = exit_q;
  assign hw_cnt_en_o = hw_cnt_en_q;

endmodule

// File: rtl/l2_mem.sv
////////////////////////////////////////////////////////////
// L2 word memory, one-cycle read latency
// Contents are not initialised
// Word index taken above the byte offset of the address
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module l2_mem (
  input  logic   clk_i,
  input  logic   rst_n_i,
  mem_if.target  bus
);

  bus_pkg::bus_word_t                  mem_q [soc_map_pkg::L2NumWords];
  bus_pkg::bus_word_t                  rdata_q;
  logic                                rvalid_q;
  logic [soc_map_pkg::L2IdxWidth-1:0]  idx;

  assign idx = bus.addr[soc_map_pkg::L2IdxWidth + bus_pkg::OffsetWidth - 1 :
                        bus_pkg::OffsetWidth];

  // Array and read data
  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      if (bus.we) begin
        mem_q[idx] <= bus_pkg::merge_be(mem_q[idx], bus.wdata, bus.be);
      end
      rdata_q <= mem_q[idx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
    end
  end

  assign bus.rdata  = rdata_q;
  assign bus.rvalid = rvalid_q;

endmodule

// File: rtl/mem_if.sv
////////////////////////////////////////////////////////////
// One request and its response between controller and target
// req is a single-cycle pulse, answered by one rvalid pulse
// rdata only carries meaning on reads
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

interface mem_if;

  logic                  req;
  logic                  we;
  bus_pkg::bus_addr_t    addr;
  bus_pkg::bus_word_t    wdata;
  bus_pkg::bus_strb_t    be;
  bus_pkg::bus_word_t    rdata;
  logic                  rvalid;

  modport initiator (
    output req, we, addr, wdata, be,
    input  rdata, rvalid
  );

  modport target (
    input  req, we, addr, wdata, be,
    output rdata, rvalid
  );

endinterface

// File: rtl/soc_map_pkg.sv
////////////////////////////////////////////////////////////
// Fixed memory map of the fabric, built on bus_pkg types
// DRAM window is exactly the L2 size, so no aliasing
// Register offsets are relative to CtrlBase
////////////////////////////////////////////////////////////

package soc_map_pkg;

  // Memory map
  localparam bus_pkg::bus_addr_t DramBase   = 32'h8000_0000;
  localparam bus_pkg::bus_addr_t DramLength = 32'h0000_2000;
  localparam bus_pkg::bus_addr_t UartBase   = 32'hC000_0000;
  localparam bus_pkg::bus_addr_t UartLength = 32'h0000_1000;
  localparam bus_pkg::bus_addr_t CtrlBase   = 32'hD000_0000;
  localparam bus_pkg::bus_addr_t CtrlLength = 32'h0000_1000;

  // Decoded target of a request
  typedef enum logic [1:0] {
    RegionDram = 2'd0,
    RegionUart = 2'd1,
    RegionCtrl = 2'd2,
    RegionNone = 2'd3
  } soc_region_e;

  // Control register offsets
  localparam bus_pkg::bus_addr_t ExitOffset    = 32'h0000_0000;
  localparam bus_pkg::bus_addr_t HwCntEnOffset = 32'h0000_0008;

  // L2 geometry
  localparam int unsigned L2NumWords = 1024;
  localparam int unsigned L2IdxWidth = 10;

endpackage

// File: rtl/soc_top.sv
////////////////////////////////////////////////////////////
// Fabric top, one requester and three targets
// Requester must hold req_i until it sees gnt_o
// UART pins follow APB without strobes
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module soc_top (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // Requester port
  input  logic               req_i,
  input  logic               we_i,
  input  bus_pkg::bus_addr_t addr_i,
  input  bus_pkg::bus_word_t wdata_i,
  input  bus_pkg::bus_strb_t be_i,
  output logic               gnt_o,
  output logic               rvalid_o,
  output bus_pkg::bus_word_t rdata_o,
  output logic               err_o,
  // Control outputs
  output bus_pkg::bus_word_t exit_o,
  output bus_pkg::bus_word_t hw_cnt_en_o,
  // UART APB
  output logic               uart_penable_o,
  output logic               uart_pwrite_o,
  output bus_pkg::bus_addr_t uart_paddr_o,
  output logic               uart_psel_o,
  output bus_pkg::apb_word_t uart_pwdata_o,
  input  bus_pkg::apb_word_t uart_prdata_i,
  input  logic               uart_pready_i,
  input  logic               uart_pslverr_i
);

  logic uart_err;

  mem_if l2_bus ();
  mem_if uart_bus ();
  mem_if ctrl_bus ();

  bus_ctrl i_bus_ctrl (
    .clk_i      (clk_i   ),
    .rst_n_i    (rst_n_i ),
    .req_i      (req_i   ),
    .we_i       (we_i    ),
    .addr_i     (addr_i  ),
    .wdata_i    (wdata_i ),
    .be_i       (be_i    ),
    .gnt_o      (gnt_o   ),
    .rvalid_o   (rvalid_o),
    .err_o      (err_o   ),
    .rdata_o    (rdata_o ),
    .uart_err_i (uart_err),
    .l2_bus     (l2_bus  ),
    .uart_bus   (uart_bus),
    .ctrl_bus   (ctrl_bus)
  );

  l2_mem i_l2_mem (
    .clk_i   (clk_i  ),
    .rst_n_i (rst_n_i),
    .bus     (l2_bus )
  );

  uart_apb_bridge i_uart_apb_bridge (
    .clk_i     (clk_i         ),
    .rst_n_i   (rst_n_i       ),
    .bus       (uart_bus      ),
    .err_o     (uart_err      ),
    .penable_o (uart_penable_o),
    .pwrite_o  (uart_pwrite_o ),
    .psel_o    (uart_psel_o   ),
    .paddr_o   (uart_paddr_o  ),
    .pwdata_o  (uart_pwdata_o ),
    .prdata_i  (uart_prdata_i ),
    .pready_i  (uart_pready_i ),
    .pslverr_i (uart_pslverr_i)
  );

  ctrl_regs i_ctrl_regs (
    .clk_i       (clk_i      ),
    .rst_n_i     (rst_n_i    ),
    .bus         (ctrl_bus   ),
    .exit_o      (exit_o     ),
    .hw_cnt_en_o (hw_cnt_en_o)
  );

endmodule

// File: rtl/uart_apb_bridge.sv
////////////////////////////////////////////////////////////
// Request to APB bridge on a single 32-bit lane
// Address bit 2 picks the lane, the other read lane is zero
// No pstrb on this port, writes cover the full lane
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module uart_apb_bridge (
  input  logic               clk_i,
  input  logic               rst_n_i,
  mem_if.target              bus,
  output logic               err_o,
  output logic               penable_o,
  output logic               pwrite_o,
  output logic               psel_o,
  output bus_pkg::bus_addr_t paddr_o,
  output bus_pkg::apb_word_t pwdata_o,
  input  bus_pkg::apb_word_t prdata_i,
  input  logic               pready_i,
  input  logic               pslverr_i
);

  // psel_q/penable_q encode idle, setup and access
  logic               psel_q;
  logic               penable_q;
  logic               rvalid_q;
  logic               err_q;
  logic               we_q;
  logic               done;
  bus_pkg::bus_addr_t addr_q;
  bus_pkg::apb_word_t pwdata_q;
  bus_pkg::bus_word_u wdata_u;
  bus_pkg::bus_word_u rdata_d;
  bus_pkg::bus_word_u rdata_q;

  assign wdata_u = bus.wdata;
  assign done    = psel_q && penable_q && pready_i;

  always_comb begin
    rdata_d                 = '0;
    rdata_d.lane[addr_q[2]] = prdata_i;
  end

  ////////////////////////////////////////////////////////////
  // Transfer control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      psel_q    <= 1'b0;
      penable_q <= 1'b0;
      rvalid_q  <= 1'b0;
      err_q     <= 1'b0;
    end else begin
      rvalid_q <= done;
      err_q    <= done && pslverr_i;
      if (!psel_q) begin
        psel_q <= bus.req;
      end else if (!penable_q) begin
        penable_q <= 1'b1;
      end else if (pready_i) begin
        psel_q    <= 1'b0;
        penable_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!psel_q && bus.req) begin
      addr_q   <= bus.addr;
      we_q     <= bus.we;
      pwdata_q <= wdata_u.lane[bus.addr[2]];
    end
    if (done) begin
      rdata_q <= rdata_d;
    end
  end

  assign psel_o    = psel_q;
  assign penable_o = penable_q;
  assign pwrite_o  = we_q;
  assign paddr_o   = addr_q;
  assign pwdata_o  = pwdata_q;

  assign bus.rdata  = rdata_q.word;
  assign bus.rvalid = rvalid_q;
  assign err_o      = err_q;

endmodule

// File: tb/soc_top_asserts.sv
////////////////////////////////////////////////////////////
// Handshake and APB rules of soc_top, bound from outside
// Checks are off while reset is low
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module soc_top_asserts (
  input logic clk_i,
  input logic rst_n_i,
  input logic req_i,
  input logic gnt_o,
  input logic rvalid_o,
  input logic uart_psel_o,
  input logic uart_penable_o
);

  // Response strobe lasts one cycle
  rvalid_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rvalid_o |=> !rvalid_o)
    else $error("rvalid_o held longer than one cycle");

  // Access phase only after one setup cycle
  apb_setup_first: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(uart_penable_o) |-> $past(uart_psel_o && !uart_penable_o))
    else $error("penable rose without a setup cycle");

  gnt_drop: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (req_i && gnt_o) |=> !gnt_o)
    else $error("gnt_o high in the cycle after acceptance");

  // Grant only comes back with the response
  gnt_return: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(gnt_o) |-> rvalid_o)
    else $error("gnt_o returned without a response");

endmodule

bind soc_top soc_top_asserts u_soc_top_asserts (
  .clk_i          (clk_i),
  .rst_n_i        (rst_n_i),
  .req_i          (req_i),
  .gnt_o          (gnt_o),
  .rvalid_o       (rvalid_o),
  .uart_psel_o    (uart_psel_o),
  .uart_penable_o (uart_penable_o)
);

// File: tb/soc_top_tb.sv
////////////////////////////////////////////////////////////
// Testbench for soc_top with an APB slave model on the UART pins
// Single outstanding request, inputs change on the falling edge
// L2 words are fully written before any partial write or read
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module soc_top_tb;

  localparam int NumWords  = 16;
  // L2 writes, partial writes and reads, then control, UART and unmapped requests
  localparam int NumTrans  = 3 * NumWords + 7 + 26 + 6;
  localparam int TimeoutNs = NumTrans * 8 * 100 + 2000;

  typedef struct packed {
    logic               rd;
    logic               timed;
    logic               err;
    bus_pkg::bus_word_t data;
    logic [31:0]        acc;
  } exp_t;

  logic               clk, rst_n;
  logic               req_i, we_i;
  bus_pkg::bus_addr_t addr_i;
  bus_pkg::bus_word_t wdata_i;
  bus_pkg::bus_strb_t be_i;
  logic               gnt_o, rvalid_o, err_o;
  bus_pkg::bus_word_t rdata_o, exit_o, hw_cnt_en_o;
  logic               psel, penable, pwrite, pready, pslverr;
  bus_pkg::bus_addr_t paddr;
  bus_pkg::apb_word_t pwdata, prdata;

  integer             seed = 32'h3a2d;
  int                 cyc = 0;
  int                 wait_cnt = 0;
  exp_t               exp_q [$];
  bus_pkg::apb_word_t apb_regs [4];
  bus_pkg::apb_word_t apb_sh [4];
  bus_pkg::bus_word_t l2_sh [soc_map_pkg::L2NumWords];
  bus_pkg::bus_word_t exit_sh, cnt_sh;

  tb_clk_gen u_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

  soc_top dut_i (
    .clk_i(clk), .rst_n_i(rst_n), .req_i(req_i), .we_i(we_i), .addr_i(addr_i),
    .wdata_i(wdata_i), .be_i(be_i), .gnt_o(gnt_o), .rvalid_o(rvalid_o),
    .rdata_o(rdata_o), .err_o(err_o), .exit_o(exit_o), .hw_cnt_en_o(hw_cnt_en_o),
    .uart_penable_o(penable), .uart_pwrite_o(pwrite), .uart_paddr_o(paddr),
    .uart_psel_o(psel), .uart_pwdata_o(pwdata), .uart_prdata_i(prdata),
    .uart_pready_i(pready), .uart_pslverr_i(pslverr)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_word(input string name, input bus_pkg::bus_word_t exp_v,
                            input bus_pkg::bus_word_t act_v);
    if (act_v !== exp_v) begin
      abort_run($sformatf("** Error @%0t: %s expected %h, got %h", $time, name, exp_v, act_v));
    end
  endtask

  task automatic check_flag(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      abort_run($sformatf("** Error @%0t: %s expected %b, got %b", $time, name, exp_v, act_v));
    end
  endtask

  // Enabled bytes from the new word, the rest kept
  function automatic bus_pkg::bus_word_t apply_bytes(input bus_pkg::bus_word_t old_w,
                                                     input bus_pkg::bus_word_t new_w,
                                                     input bus_pkg::bus_strb_t be);
    bus_pkg::bus_word_t mask;
    for (int b = 0; b < 8; b++) begin
      mask[8*b +: 8] = {8{be[b]}};
    end
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  // Reference model returning the error flag and updating the shadows
  function automatic logic ref_access(input logic we, input bus_pkg::bus_addr_t addr,
                                      input bus_pkg::bus_word_t wdata,
                                      input bus_pkg::bus_strb_t be,
                                      output bus_pkg::bus_word_t data);
    bus_pkg::bus_addr_t off;
    int                 idx;
    data = '0;
    if (addr >= 32'h8000_0000 && addr < 32'h8000_2000) begin
      idx = int'((addr - 32'h8000_0000) >> 3);
      if (we) l2_sh[idx] = apply_bytes(l2_sh[idx], wdata, be);
      else data = l2_sh[idx];
      return 1'b0;
    end
    if (addr >= 32'hD000_0000 && addr < 32'hD000_1000) begin
      off = addr - 32'hD000_0000;
      if (off == 32'h0) begin
        if (we) exit_sh = apply_bytes(exit_sh, wdata, be);
        else data = exit_sh;
      end else if (off == 32'h8) begin
        if (we) cnt_sh = apply_bytes(cnt_sh, wdata, be);
        else data = cnt_sh;
      end
      return 1'b0;
    end
    if (addr >= 32'hC000_0000 && addr < 32'hC000_1000) begin
      off = addr - 32'hC000_0000;
      if (off >= 32'h10) return 1'b1;
      idx = int'(off[3:2]);
      if (we) apb_sh[idx] = off[2] ? wdata[63:32] : wdata[31:0];
      else if (off[2]) data[63:32] = apb_sh[idx];
      else data[31:0] = apb_sh[idx];
      return 1'b0;
    end
    return 1'b1;
  endfunction

  // Issues one request and waits until its response is checked
  task automatic do_access(input logic we, input bus_pkg::bus_addr_t addr,
                           input bus_pkg::bus_word_t wdata, input bus_pkg::bus_strb_t be);
    exp_t e;
    bus_pkg::bus_word_t d;
    e.err   = ref_access(we, addr, wdata, be, d);
    e.data  = d;
    e.rd    = !we;
    e.timed = !(addr >= 32'hC000_0000 && addr < 32'hC000_1000);
    req_i   = 1'b1;
    we_i    = we;
    addr_i  = addr;
    wdata_i = wdata;
    be_i    = be;
    while (!gnt_o) @(negedge clk);
    e.acc = cyc + 1;
    exp_q.push_back(e);
    @(negedge clk);
    req_i = 1'b0;
    while (exp_q.size() != 0) @(negedge clk);
  endtask

  always @(posedge clk) cyc <= cyc + 1;

  // APB slave model with random wait states
  always @(negedge clk) begin
    if (psel && !penable) begin
      wait_cnt = $random(seed) & 3;
      pready   = 1'b0;
    end else if (psel && penable && !pready) begin
      if (wait_cnt == 0) begin
        pready  = 1'b1;
        pslverr = (paddr >= 32'h10);
        prdata  = pslverr ? '0 : apb_regs[paddr[3:2]];
        if (pwrite && !pslverr) apb_regs[paddr[3:2]] = pwdata;
      end else begin
        wait_cnt--;
      end
    end else begin
      pready  = 1'b0;
      pslverr = 1'b0;
    end
  end

  // Response checker
  always @(negedge clk) begin
    exp_t e;
    if (rst_n && rvalid_o) begin
      if (exp_q.size() == 0) abort_run("Response seen with no request outstanding");
      e = exp_q.pop_front();
      if (e.timed && cyc != int'(e.acc) + 1) begin
        abort_run($sformatf("Response came %0d cycles after acceptance instead of 1",
                            cyc - int'(e.acc)));
      end
      check_flag("err_o", e.err, err_o);
      if (e.rd) check_word("rdata_o", e.data, rdata_o);
    end
  end

  initial begin
    #(TimeoutNs);
    abort_run("No response in time, watchdog expired");
  end

  initial begin
    bus_pkg::bus_addr_t a;
    bus_pkg::bus_word_t w;
    req_i   = 1'b0;
    we_i    = 1'b0;
    addr_i  = '0;
    wdata_i = '0;
    be_i    = '0;
    prdata  = '0;
    pready  = 1'b0;
    pslverr = 1'b0;
    exit_sh = '0;
    cnt_sh  = '0;
    for (int i = 0; i < 4; i++) begin
      apb_regs[i] = '0;
      apb_sh[i]   = '0;
    end
    @(posedge rst_n);
    @(negedge clk);
    check_flag("gnt_o", 1'b1, gnt_o);
    check_flag("rvalid_o", 1'b0, rvalid_o);
    check_flag("uart_psel_o", 1'b0, psel);
    check_word("exit_o", '0, exit_o);
    check_word("hw_cnt_en_o", '0, hw_cnt_en_o);

    ////////////////////////////////////////////////////////////
    // L2
    ////////////////////////////////////////////////////////////
    for (int i = 0; i < NumWords; i++) begin
      w = {$random(seed), $random(seed)};
      do_access(1'b1, 32'h8000_0000 + bus_pkg::bus_addr_t'(((i * 67) % 1024) * 8), w, 8'hff);
    end
    for (int i = 0; i < NumWords; i++) begin
      w = {$random(seed), $random(seed)};
      do_access(1'b1, 32'h8000_0000 + bus_pkg::bus_addr_t'(((i * 67) % 1024) * 8), w,
                bus_pkg::bus_strb_t'($random(seed)));
    end
    for (int i = 0; i < NumWords; i++) begin
      do_access(1'b0, 32'h8000_0000 + bus_pkg::bus_addr_t'(((i * 67) % 1024) * 8), '0, '0);
    end

    ////////////////////////////////////////////////////////////
    // Control registers
    ////////////////////////////////////////////////////////////
    do_access(1'b1, 32'hD000_0000, 64'h0123_4567_89ab_cdef, 8'hff);
    check_word("exit_o", exit_sh, exit_o);
    do_access(1'b1, 32'hD000_0008, 64'hffff_ffff_ffff_ffff, 8'h0f);
    check_word("hw_cnt_en_o", cnt_sh, hw_cnt_en_o);
    do_access(1'b1, 32'hD000_0010, 64'hdead_beef_dead_beef, 8'hff);
    do_access(1'b0, 32'hD000_0000, '0, '0);
    do_access(1'b0, 32'hD000_0008, '0, '0);
    do_access(1'b0, 32'hD000_0010, '0, '0);
    do_access(1'b0, 32'hD000_0004, '0, '0);

    ////////////////////////////////////////////////////////////
    // UART over APB, both lanes
    ////////////////////////////////////////////////////////////
    for (int i = 0; i < 4; i++) begin
      do_access(1'b1, 32'hC000_0000 + bus_pkg::bus_addr_t'(i * 4),
                {$random(seed), $random(seed)}, 8'hff);
      do_access(1'b0, 32'hC000_0000 + bus_pkg::bus_addr_t'(i * 4), '0, '0);
    end
    for (int i = 0; i < 16; i++) begin
      a = 32'hC000_0000 + bus_pkg::bus_addr_t'(($random(seed) & 3) * 4);
      do_access(i[0], a, {$random(seed), $random(seed)}, 8'hff);
    end
    do_access(1'b1, 32'hC000_0010, 64'h1111_2222_3333_4444, 8'hff);
    do_access(1'b0, 32'hC000_0024, '0, '0);

    ////////////////////////////////////////////////////////////
    // Unmapped
    ////////////////////////////////////////////////////////////
    do_access(1'b0, 32'h0000_0000, '0, '0);
    do_access(1'b1, 32'h8000_2000, 64'h5555_5555_5555_5555, 8'hff);
    do_access(1'b1, 32'hC000_1000, 64'h6666_6666_6666_6666, 8'hff);
    do_access(1'b0, 32'hFFFF_FFF8, '0, '0);
    check_word("exit_o", exit_sh, exit_o);
    check_word("hw_cnt_en_o", cnt_sh, hw_cnt_en_o);
    do_access(1'b0, 32'h8000_0000, '0, '0);
    do_access(1'b0, 32'hC000_0000, '0, '0);

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// File: tb/tb_clk_gen.sv
////////////////////////////////////////////////////////////
// Testbench clock and reset source
// 100 ns period, reset low for the first 5 rising edges
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (5) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule
